// ==== include/decoder_macros.svh ====
`ifndef DECODER_MACROS_SVH
`define DECODER_MACROS_SVH

`define CHAIN_LENGTH 8
`define ADDRESS_WIDTH 3
`define NEIGHBOR_COUNT 2 // 0 is left, 1 is right
`define GROWTH_LIMIT 2
`define STAGE_WIDTH 3

// Word that one unit exposes to one neighbour
`define EXP_ROOT 0
`define EXP_PARENT (`ADDRESS_WIDTH)
`define EXP_ODD (`ADDRESS_WIDTH + 1)
`define EXP_PARITY (`ADDRESS_WIDTH + 2)
`define EXP_BOUNDARY (`ADDRESS_WIDTH + 3)
`define EXP_PEEL_DONE (`ADDRESS_WIDTH + 4)
`define EXP_PEEL_M (`ADDRESS_WIDTH + 5)
`define EXP_PEEL_PARITY_DONE (`ADDRESS_WIDTH + 6)
`define EXPOSED_DATA_SIZE (`ADDRESS_WIDTH + 7)

`endif

// ==== src/decoder_pkg.sv ====
`include "decoder_macros.svh"

package decoder_pkg;

    typedef enum logic [`STAGE_WIDTH-1:0] {
        STAGE_IDLE,
        STAGE_MEASUREMENT_PREPARING,
        STAGE_MEASUREMENT_LOADING,
        STAGE_GROW,
        STAGE_MERGE,
        STAGE_PEELING,
        STAGE_RESULT
    } stage_t;

endpackage

// ==== src/min_root_select.sv ====
`timescale 1ns/10ps
`include "decoder_macros.svh"

module min_root_select (
    input  logic [`NEIGHBOR_COUNT*`ADDRESS_WIDTH-1:0] values,
    input  logic [`NEIGHBOR_COUNT-1:0]                valids,
    output logic [`ADDRESS_WIDTH-1:0]                 result,
    output logic [`NEIGHBOR_COUNT-1:0]                output_valids
);

    logic found;

    always_comb begin
        result = '0;
        found = 1'b0;
        for (int i = 0; i < `NEIGHBOR_COUNT; i++) begin
            if (valids[i] && (!found || values[i*`ADDRESS_WIDTH +: `ADDRESS_WIDTH] < result)) begin
                result = values[i*`ADDRESS_WIDTH +: `ADDRESS_WIDTH];
                found = 1'b1;
            end
        end
        // Every valid channel carrying the minimum is marked
        for (int i = 0; i < `NEIGHBOR_COUNT; i++) begin
            output_valids[i] = valids[i] &&
                               (values[i*`ADDRESS_WIDTH +: `ADDRESS_WIDTH] == result);
        end
    end

endmodule

// ==== src/processing_unit.sv ====
`timescale 1ns/10ps
`include "decoder_macros.svh"

module processing_unit #(
    parameter ADDRESS = 0
) (
    input  logic                                         clk,
    input  logic                                         reset,
    input  logic                                         measurement,
    input  decoder_pkg::stage_t                          global_stage,
    input  logic [`NEIGHBOR_COUNT-1:0]                   neighbor_fully_grown,
    input  logic [`NEIGHBOR_COUNT-1:0]                   neighbor_is_boundary,
    output logic                                         neighbor_increase,
    output logic [`NEIGHBOR_COUNT-1:0]                   neighbor_is_error,
    input  logic [`NEIGHBOR_COUNT*`EXPOSED_DATA_SIZE-1:0] input_data,
    output logic [`NEIGHBOR_COUNT*`EXPOSED_DATA_SIZE-1:0] output_data,
    output logic                                         odd,
    output logic [`ADDRESS_WIDTH-1:0]                    root,
    output logic                                         busy
);

    localparam int W = `EXPOSED_DATA_SIZE;

    logic [`NEIGHBOR_COUNT*`ADDRESS_WIDTH-1:0] neighbor_root;
    logic [`NEIGHBOR_COUNT-1:0] neighbor_parent_vector; // Neighbour names me as parent
    logic [`NEIGHBOR_COUNT-1:0] parent_odd;
    logic [`NEIGHBOR_COUNT-1:0] child_parity;
    logic [`NEIGHBOR_COUNT-1:0] child_boundary;
    logic [`NEIGHBOR_COUNT-1:0] child_peel_done;
    logic [`NEIGHBOR_COUNT-1:0] child_peel_m;
    logic [`NEIGHBOR_COUNT-1:0] parent_peel_parity_done;

    logic [`NEIGHBOR_COUNT-1:0] parent_vector;
    logic [`NEIGHBOR_COUNT-1:0] odd_to_children;
    logic cluster_parity;
    logic cluster_boundary;
    logic peeling_complete;
    logic peeling_m;
    logic peeling_parity_completed;

    for (genvar i = 0; i < `NEIGHBOR_COUNT; i++) begin : g_side
        assign neighbor_root[i*`ADDRESS_WIDTH +: `ADDRESS_WIDTH] =
            input_data[i*W + `EXP_ROOT +: `ADDRESS_WIDTH];
        assign neighbor_parent_vector[i]  = input_data[i*W + `EXP_PARENT];
        assign parent_odd[i]              = input_data[i*W + `EXP_ODD];
        assign child_parity[i]            = input_data[i*W + `EXP_PARITY];
        assign child_boundary[i]          = input_data[i*W + `EXP_BOUNDARY];
        assign child_peel_done[i]         = input_data[i*W + `EXP_PEEL_DONE];
        assign child_peel_m[i]            = input_data[i*W + `EXP_PEEL_M];
        assign parent_peel_parity_done[i] = input_data[i*W + `EXP_PEEL_PARITY_DONE];

        assign output_data[i*W + `EXP_ROOT +: `ADDRESS_WIDTH] = root;
        assign output_data[i*W + `EXP_PARENT]           = parent_vector[i];
        assign output_data[i*W + `EXP_ODD]              = odd_to_children[i];
        assign output_data[i*W + `EXP_PARITY]           = cluster_parity;
        assign output_data[i*W + `EXP_BOUNDARY]         = cluster_boundary;
        assign output_data[i*W + `EXP_PEEL_DONE]        = peeling_complete;
        assign output_data[i*W + `EXP_PEEL_M]           = peeling_m;
        assign output_data[i*W + `EXP_PEEL_PARITY_DONE] = peeling_parity_completed;
    end

    function automatic logic [`NEIGHBOR_COUNT-1:0] lowest_first(
        input logic [`NEIGHBOR_COUNT-1:0] v
    );
        return v & (~v + 1'b1);
    endfunction

    decoder_pkg::stage_t stage;
    decoder_pkg::stage_t last_stage;

    always_ff @(posedge clk) begin
        if (reset) begin
            stage <= decoder_pkg::STAGE_IDLE;
            last_stage <= decoder_pkg::STAGE_IDLE;
        end else begin
            stage <= global_stage;
            last_stage <= stage;
        end
    end

    logic in_loading;
    logic in_merge;
    logic in_peeling;
    assign in_loading = (stage == decoder_pkg::STAGE_MEASUREMENT_LOADING);
    assign in_merge   = (stage == decoder_pkg::STAGE_MERGE);
    assign in_peeling = (stage == decoder_pkg::STAGE_PEELING);

    // Syndrome is only valid alongside start, so keep sampling while idle
    logic m;
    always_ff @(posedge clk) begin
        if (reset) begin
            m <= 1'b0;
        end else if (global_stage == decoder_pkg::STAGE_IDLE) begin
            m <= measurement;
        end
    end

    assign neighbor_increase = odd && (stage == decoder_pkg::STAGE_GROW) &&
                               (last_stage != decoder_pkg::STAGE_GROW);

    logic [`ADDRESS_WIDTH-1:0] sel_root;
    logic [`NEIGHBOR_COUNT-1:0] sel_valids;
    logic root_move;

    min_root_select u_min_root (
        .values(neighbor_root),
        .valids(neighbor_fully_grown & ~neighbor_is_boundary),
        .result(sel_root),
        .output_valids(sel_valids)
    );

    assign root_move = (|sel_valids) && (sel_root < root);

    always_ff @(posedge clk) begin
        if (reset || in_loading) begin
            root <= `ADDRESS_WIDTH'(ADDRESS);
            parent_vector <= '0;
        end else if (in_merge && root_move) begin
            root <= sel_root;
            parent_vector <= sel_valids; // Follow the smaller root
        end
    end

    logic next_parity;
    logic next_boundary;
    logic has_parent;
    logic parent_is_odd;
    logic merge_odd;
    assign next_parity   = (^(neighbor_parent_vector & child_parity)) ^ m;
    assign next_boundary = (|(neighbor_parent_vector & child_boundary)) | (|neighbor_is_boundary);
    assign has_parent    = |parent_vector;
    assign parent_is_odd = |(parent_vector & parent_odd);
    assign merge_odd     = has_parent ? parent_is_odd : (next_parity & ~next_boundary);

    always_ff @(posedge clk) begin
        if (reset) begin
            cluster_parity <= 1'b0;
            cluster_boundary <= 1'b0;
        end else if (in_loading) begin
            cluster_parity <= m;
            cluster_boundary <= 1'b0;
        end else if (in_merge) begin
            cluster_parity <= next_parity;
            cluster_boundary <= next_boundary;
        end
    end

    // The root decides oddness; peeling sends it down toward the boundary
    always_ff @(posedge clk) begin
        if (reset) begin
            odd <= 1'b0;
            odd_to_children <= '0;
        end else if (in_loading) begin
            odd <= m;
            odd_to_children <= {`NEIGHBOR_COUNT{m}};
        end else if (in_merge) begin
            odd <= merge_odd;
            odd_to_children <= {`NEIGHBOR_COUNT{merge_odd}};
        end else if (in_peeling) begin
            if (has_parent ? !parent_is_odd : !next_parity) begin
                odd <= 1'b0;
                odd_to_children <= '0;
            end else if (|neighbor_is_boundary) begin
                odd <= 1'b1; // Boundary edge takes the defect
                odd_to_children <= '0;
            end else begin
                odd <= !has_parent;
                odd_to_children <= lowest_first(neighbor_parent_vector & child_boundary);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset || in_loading) begin
            peeling_parity_completed <= 1'b0;
        end else if (in_peeling) begin
            peeling_parity_completed <= !has_parent ||
                                        (|(parent_vector & parent_peel_parity_done));
        end
    end

    logic peel_pending;
    assign peel_pending = (|(neighbor_parent_vector & ~child_peel_done)) ||
                          !peeling_parity_completed;

    always_ff @(posedge clk) begin
        if (reset || in_loading) begin
            peeling_complete <= 1'b0;
        end else if (in_peeling) begin
            peeling_complete <= !peel_pending;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            peeling_m <= 1'b0;
        end else if (in_peeling && last_stage != decoder_pkg::STAGE_PEELING) begin
            peeling_m <= m;
        end else if (in_peeling && !peel_pending) begin
            peeling_m <= m ^ (^(neighbor_parent_vector & child_peel_m)) ^ odd;
        end
    end

    // Children with leftover parity and the boundary side when odd
    assign neighbor_is_error = (in_peeling && !peel_pending) ?
        ((neighbor_parent_vector & child_peel_m) |
         (odd ? lowest_first(neighbor_is_boundary) : '0)) : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
        end else if (in_merge) begin
            busy <= root_move || (next_parity != cluster_parity) ||
                    (next_boundary != cluster_boundary) || (merge_odd != odd);
        end else if (in_peeling) begin
            busy <= peel_pending;
        end
    end

    assert property (@(posedge clk) disable iff (reset) $onehot0(parent_vector));

    // Controller is still peeling or just moved on to the result
    assert property (@(posedge clk) disable iff (reset)
        |neighbor_is_error |-> global_stage == decoder_pkg::STAGE_PEELING ||
                               global_stage == decoder_pkg::STAGE_RESULT);

endmodule

// ==== src/edge_growth.sv ====
`timescale 1ns/10ps
`include "decoder_macros.svh"

module edge_growth (
    input  logic                clk,
    input  logic                reset,
    input  decoder_pkg::stage_t global_stage,
    input  logic [1:0]          increase,
    output logic                fully_grown,
    input  logic [1:0]          error_mark,
    output logic                correction
);

    localparam int COUNT_WIDTH = $clog2(`GROWTH_LIMIT + 1);

    logic [COUNT_WIDTH-1:0] count;
    logic [COUNT_WIDTH:0]   count_sum;
    logic                   clear;

    assign clear = (global_stage == decoder_pkg::STAGE_MEASUREMENT_LOADING);
    assign count_sum = count + increase[0] + increase[1]; // Both sides may grow at once

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            count <= '0;
            correction <= 1'b0;
        end else begin
            if (count_sum > `GROWTH_LIMIT) begin
                count <= COUNT_WIDTH'(`GROWTH_LIMIT);
            end else begin
                count <= count_sum[COUNT_WIDTH-1:0];
            end
            correction <= correction | (|error_mark); // Sticky until next load
        end
    end

    assign fully_grown = (count == COUNT_WIDTH'(`GROWTH_LIMIT));

    assert property (@(posedge clk) disable iff (reset) count <= `GROWTH_LIMIT);

endmodule

// ==== src/stage_controller.sv ====
`timescale 1ns/10ps
`include "decoder_macros.svh"

module stage_controller (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  logic                any_busy,
    input  logic                any_odd,
    output decoder_pkg::stage_t global_stage,
    output logic                done,
    output logic                busy
);

    // Units register the stage, so their busy flags lag by two cycles
    localparam logic [1:0] SETTLE_CYCLES = 2'd2;

    logic [1:0] settle_count;
    logic       settled;

    assign settled = (settle_count == SETTLE_CYCLES);

    always_ff @(posedge clk) begin
        if (reset) begin
            global_stage <= decoder_pkg::STAGE_IDLE;
            settle_count <= '0;
            done <= 1'b0;
            busy <= 1'b0;
        end else begin
            done <= 1'b0;
            case (global_stage)
                decoder_pkg::STAGE_IDLE: begin
                    if (start) begin
                        global_stage <= decoder_pkg::STAGE_MEASUREMENT_PREPARING;
                        busy <= 1'b1;
                    end
                end
                decoder_pkg::STAGE_MEASUREMENT_PREPARING: begin
                    global_stage <= decoder_pkg::STAGE_MEASUREMENT_LOADING;
                end
                decoder_pkg::STAGE_MEASUREMENT_LOADING: begin
                    global_stage <= decoder_pkg::STAGE_GROW;
                end
                decoder_pkg::STAGE_GROW: begin
                    global_stage <= decoder_pkg::STAGE_MERGE;
                end
                decoder_pkg::STAGE_MERGE: begin
                    if (!settled) begin
                        settle_count <= settle_count + 1'b1;
                    end else if (!any_busy) begin
                        settle_count <= '0;
                        global_stage <= any_odd ? decoder_pkg::STAGE_GROW
                                                : decoder_pkg::STAGE_PEELING;
                    end
                end
                decoder_pkg::STAGE_PEELING: begin
                    if (!settled) begin
                        settle_count <= settle_count + 1'b1;
                    end else if (!any_busy) begin
                        settle_count <= '0;
                        global_stage <= decoder_pkg::STAGE_RESULT;
                        done <= 1'b1;
                    end
                end
                default: begin // Result
                    global_stage <= decoder_pkg::STAGE_IDLE;
                    busy <= 1'b0;
                end
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        done |-> global_stage == decoder_pkg::STAGE_RESULT &&
                 $past(global_stage) == decoder_pkg::STAGE_PEELING);

endmodule

// ==== src/repetition_decoder.sv ====
`timescale 1ns/10ps
`include "decoder_macros.svh"

module repetition_decoder (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     start,
    input  logic [`CHAIN_LENGTH-1:0] syndrome,
    output logic                     done,
    output logic                     busy,
    output wire  [`CHAIN_LENGTH:0]   correction
);

    localparam int CL = `CHAIN_LENGTH;
    localparam int W  = 2 * `EXPOSED_DATA_SIZE;

    decoder_pkg::stage_t global_stage;

    wire [CL-1:0] unit_busy;
    wire [CL-1:0] unit_odd;
    wire [CL-1:0] unit_increase;
    wire [CL-1:0] error_left;  // Unit k marks edge k
    wire [CL-1:0] error_right; // Unit k marks edge k+1
    wire [CL:0]   edge_full;

    // Unit k sits at index k+1; the ends stand in for missing neighbours
    wire [CL+1:0][W-1:0] unit_word;
    assign unit_word[0]    = '0;
    assign unit_word[CL+1] = '0;

    stage_controller u_controller (
        .clk(clk),
        .reset(reset),
        .start(start),
        .any_busy(|unit_busy),
        .any_odd(|unit_odd),
        .global_stage(global_stage),
        .done(done),
        .busy(busy)
    );

    for (genvar k = 0; k < CL; k++) begin : g_unit
        processing_unit #(
            .ADDRESS(k)
        ) u_unit (
            .clk(clk),
            .reset(reset),
            .measurement(syndrome[k]),
            .global_stage(global_stage),
            .neighbor_fully_grown({edge_full[k+1] & (k != CL-1), edge_full[k] & (k != 0)}),
            .neighbor_is_boundary({edge_full[k+1] & (k == CL-1), edge_full[k] & (k == 0)}),
            .neighbor_increase(unit_increase[k]),
            .neighbor_is_error({error_right[k], error_left[k]}),
            .input_data({unit_word[k+2][`EXPOSED_DATA_SIZE-1:0],
                         unit_word[k][W-1:`EXPOSED_DATA_SIZE]}),
            .output_data(unit_word[k+1]),
            .odd(unit_odd[k]),
            .root(),
            .busy(unit_busy[k])
        );
    end

    // Edge j lies between unit j-1 and unit j
    wire [CL:0] increase_from_left  = {unit_increase, 1'b0};
    wire [CL:0] increase_from_right = {1'b0, unit_increase};
    wire [CL:0] error_from_left     = {error_right, 1'b0};
    wire [CL:0] error_from_right    = {1'b0, error_left};

    for (genvar j = 0; j <= CL; j++) begin : g_edge
        edge_growth u_edge (
            .clk(clk),
            .reset(reset),
            .global_stage(global_stage),
            .increase({increase_from_right[j], increase_from_left[j]}),
            .fully_grown(edge_full[j]),
            .error_mark({error_from_right[j], error_from_left[j]}),
            .correction(correction[j])
        );
    end

endmodule

// ==== tests/repetition_decoder_tb.sv ====
`timescale 1ns/10ps
`include "decoder_macros.svh"

module repetition_decoder_tb;

    localparam int CL = `CHAIN_LENGTH;
    localparam int TABLE_SIZE = 10;
    localparam int RANDOM_RUNS = 20;
    localparam int DONE_TIMEOUT = 500; // Cycles from start to done

    logic          clk;
    logic          reset;
    logic          start;
    logic [CL-1:0] syndrome;
    logic          done;
    logic          busy;
    logic [CL:0]   correction;

    // Stimulus table, expected correction used only where known is set
    string         table_name [TABLE_SIZE];
    logic [CL-1:0] table_syndrome [TABLE_SIZE];
    logic [CL:0]   table_expected [TABLE_SIZE];
    logic          table_known [TABLE_SIZE];

    repetition_decoder u_dut (
        .clk(clk),
        .reset(reset),
        .start(start),
        .syndrome(syndrome),
        .done(done),
        .busy(busy),
        .correction(correction)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic add_entry(input int idx, input string name, input logic [CL-1:0] s,
                             input logic known, input logic [CL:0] expected);
        table_name[idx] = name;
        table_syndrome[idx] = s;
        table_known[idx] = known;
        table_expected[idx] = expected;
    endtask

    task automatic load_table();
        add_entry(0, "zero", 8'h00, 1'b1, 9'h000);
        add_entry(1, "single_left", 8'h01, 1'b1, 9'h001); // Nearest boundary is edge 0
        add_entry(2, "single_right", 8'h80, 1'b1, 9'h100);
        add_entry(3, "pair_2_3", 8'h0C, 1'b1, 9'h008);    // Shared edge 3
        add_entry(4, "pair_3_4", 8'h18, 1'b1, 9'h010);
        add_entry(5, "pair_4_5", 8'h30, 1'b1, 9'h020);
        add_entry(6, "all_ones", 8'hFF, 1'b0, 9'h000);
        add_entry(7, "alternating", 8'h55, 1'b0, 9'h000);
        add_entry(8, "both_ends", 8'h81, 1'b0, 9'h000);
        add_entry(9, "middle_single", 8'h10, 1'b0, 9'h000);
    endtask

    function automatic logic [31:0] next_random(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_correction(input string name, input logic [CL:0] expected,
                                    input logic [CL:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Stopping at first error");
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("MISMATCH %s expected %b actual %b", name, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Stopping at first error");
        end
    endtask

    // Each ancilla sees the XOR of its two edges
    task automatic confirm_syndrome(input string name, input logic [CL-1:0] s,
                                    input logic [CL:0] c);
        for (int k = 0; k < CL; k++) begin
            check_flag($sformatf("%s ancilla %0d parity", name, k), s[k], c[k] ^ c[k+1]);
        end
    endtask

    task automatic run_decode(input string name, input logic [CL-1:0] s,
                              output logic [CL:0] result);
        int cycles;
        cycles = 0;
        @(negedge clk);
        start = 1'b1;
        syndrome = s;
        @(negedge clk);
        start = 1'b0;
        while (done !== 1'b1) begin
            check_flag({name, " busy"}, 1'b1, busy);
            @(negedge clk);
            cycles++;
            if (cycles > DONE_TIMEOUT) begin
                $display("Timeout: done did not arrive within %0d cycles in test %s",
                         DONE_TIMEOUT, name);
                $display("TEST RESULT: FAIL");
                $fatal(1, "Decoder did not finish");
            end
        end
        check_flag({name, " busy at done"}, 1'b1, busy);
        result = correction;
        @(negedge clk); // Controller back in idle here
        check_flag({name, " done pulse"}, 1'b0, done);
        check_flag({name, " busy after done"}, 1'b0, busy);
        check_correction({name, " held correction"}, result, correction);
    endtask

    initial begin
        logic [CL:0] result;
        logic [CL:0] first_result;
        logic [31:0] lcg_state;
        string       name;

        reset = 1'b1;
        start = 1'b0;
        syndrome = '0;
        load_table();
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_flag("reset done", 1'b0, done);
        check_flag("reset busy", 1'b0, busy);
        check_correction("reset correction", '0, correction);

        for (int i = 0; i < TABLE_SIZE; i++) begin
            run_decode(table_name[i], table_syndrome[i], result);
            if (table_known[i]) begin
                check_correction(table_name[i], table_expected[i], result);
            end
            confirm_syndrome(table_name[i], table_syndrome[i], result);
        end

        // Same syndrome twice in a row must decode the same way
        run_decode("repeat_first", 8'h5A, first_result);
        confirm_syndrome("repeat_first", 8'h5A, first_result);
        run_decode("repeat_second", 8'h5A, result);
        check_correction("repeat_second", first_result, result);

        lcg_state = 32'd70;
        for (int i = 0; i < RANDOM_RUNS; i++) begin
            lcg_state = next_random(lcg_state);
            name = $sformatf("random_%0d", i);
            run_decode(name, lcg_state[23:16], result);
            confirm_syndrome(name, lcg_state[23:16], result);
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+include
src/decoder_pkg.sv
src/min_root_select.sv
src/processing_unit.sv
src/edge_growth.sv
src/stage_controller.sv
src/repetition_decoder.sv
tests/repetition_decoder_tb.sv
